// ==== logic/csr_pkg.sv ====
package csr_pkg;

    // datapath width of every CSR and of the APB data bus
    localparam int XLEN = 32;

    // csr address and op code widths
    localparam int CSR_ADDR_W = 12;
    localparam int CSR_OP_W = 2;

    // op encoding as carried in the CMD register
    typedef enum logic [CSR_OP_W-1:0] {
        CSR_OP_RW = 2'd0,
        CSR_OP_RS = 2'd1,
        CSR_OP_RC = 2'd2
    } csr_op_e;

    // machine-mode csr addresses held by each lane
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIE = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE = 12'h342;
    // read-only, writes are dropped
    localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID = 12'hF14;

    // apb register map, byte offsets
    localparam int APB_ADDR_W = 8;
    localparam logic [APB_ADDR_W-1:0] REG_OPERAND = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_CMD = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_INT = 8'h08;
    // status and result are read-only
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_RESULT = 8'h10;

    // CMD word layout
    // [11:0] csr address, [13:12] op, [23:16] hart index
    localparam int CMD_ADDR_LSB = 0;
    localparam int CMD_OP_LSB = 12;
    localparam int CMD_HART_LSB = 16;
    localparam int CMD_HART_W = 8;

    // STATUS word layout
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_ERR_BIT = 1;

endpackage

// ==== logic/exu_csr_unit.sv ====
`timescale 1ns/10ps

module exu_csr_unit (
    // request from the lane
    input  logic                     req_csr_i,
    input  csr_pkg::csr_op_e         csr_op_i,
    input  logic [csr_pkg::XLEN-1:0] csr_op1_i,
    // current value of the addressed csr
    input  logic [csr_pkg::XLEN-1:0] csr_rdata_i,

    // hart is taking an interrupt
    input  logic                     int_assert_i,

    // new csr value and its write enable
    output logic [csr_pkg::XLEN-1:0] csr_wdata_o,
    output logic                     csr_we_o,

    // old value for the destination register
    output logic [csr_pkg::XLEN-1:0] reg_wdata_o
);
    import csr_pkg::*;

    always_comb begin
        // idle defaults
        csr_wdata_o = '0;
        reg_wdata_o = '0;
        csr_we_o = 1'b0;

        if (int_assert_i) begin
            // interrupt pending, csr access is blocked
            csr_wdata_o = '0;
        end else if (req_csr_i) begin
            // every form returns the old value
            reg_wdata_o = csr_rdata_i;

            case (csr_op_i)
                CSR_OP_RW: begin
                    // plain swap
                    csr_wdata_o = csr_op1_i;
                    csr_we_o = 1'b1;
                end
                CSR_OP_RS: begin
                    // set bits given in operand
                    csr_wdata_o = csr_rdata_i | csr_op1_i;
                    csr_we_o = 1'b1;
                end
                CSR_OP_RC: begin
                    // clear bits given in operand
                    csr_wdata_o = csr_rdata_i & ~csr_op1_i;
                    csr_we_o = 1'b1;
                end
                default: begin
                    // reserved op, read only
                    csr_we_o = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== logic/csr_hart_lane.sv ====
`timescale 1ns/10ps

module csr_hart_lane #(
    parameter int HART_ID = 0
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // request from the frontend
    input  logic                           req_i,
    input  csr_pkg::csr_op_e               op_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] addr_i,
    input  logic [csr_pkg::XLEN-1:0]       operand_i,
    input  logic                           int_assert_i,

    // registered response to the collector
    output logic                           rsp_valid_o,
    output logic [csr_pkg::XLEN-1:0]       rsp_data_o,
    output logic                           rsp_err_o
);
    import csr_pkg::*;

    // fixed hart id seen through mhartid
    localparam logic [XLEN-1:0] MHARTID_VAL = XLEN'(HART_ID);

    // csr bank
    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;

    // decode results
    logic [XLEN-1:0] csr_rdata;
    logic            csr_hit;
    logic            csr_ro;

    // exu outputs
    logic [XLEN-1:0] csr_wdata;
    logic [XLEN-1:0] reg_wdata;
    logic            csr_we;
    logic            bank_we;

    // address decode, miss reads as zero
    always_comb begin
        csr_rdata = '0;
        csr_hit = 1'b1;
        csr_ro = 1'b0;
        case (addr_i)
            ADDR_MSTATUS: csr_rdata = mstatus_q;
            ADDR_MIE: csr_rdata = mie_q;
            ADDR_MTVEC: csr_rdata = mtvec_q;
            ADDR_MSCRATCH: csr_rdata = mscratch_q;
            ADDR_MEPC: csr_rdata = mepc_q;
            ADDR_MCAUSE: csr_rdata = mcause_q;
            ADDR_MHARTID: begin
                csr_rdata = MHARTID_VAL;
                csr_ro = 1'b1;
            end
            default: csr_hit = 1'b0;
        endcase
    end

    exu_csr_unit u_exu_csr_unit (
        .req_csr_i    (req_i),
        .csr_op_i     (op_i),
        .csr_op1_i    (operand_i),
        .csr_rdata_i  (csr_rdata),
        .int_assert_i (int_assert_i),
        .csr_wdata_o  (csr_wdata),
        .csr_we_o     (csr_we),
        .reg_wdata_o  (reg_wdata)
    );

    // mhartid write is silently dropped here
    assign bank_we = csr_we & csr_hit & ~csr_ro;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mstatus_q <= '0;
            mie_q <= '0;
            mtvec_q <= '0;
            mscratch_q <= '0;
            mepc_q <= '0;
            mcause_q <= '0;
        end else if (bank_we) begin
            case (addr_i)
                ADDR_MSTATUS: mstatus_q <= csr_wdata;
                ADDR_MIE: mie_q <= csr_wdata;
                ADDR_MTVEC: mtvec_q <= csr_wdata;
                ADDR_MSCRATCH: mscratch_q <= csr_wdata;
                ADDR_MEPC: mepc_q <= csr_wdata;
                ADDR_MCAUSE: mcause_q <= csr_wdata;
                default: ;
            endcase
        end
    end

    // response strobe one cycle after the request
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
            rsp_err_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_i;
            if (req_i) begin
                rsp_err_o <= ~csr_hit;
            end
        end
    end

    // old value, zero on miss or blocked access
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rsp_data_o <= reg_wdata;
        end
    end

endmodule

// ==== logic/csr_apb_frontend.sv ====
`timescale 1ns/10ps

module csr_apb_frontend #(
    parameter int NUM_HARTS = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // apb slave
    input  logic [csr_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [csr_pkg::XLEN-1:0]       pwdata_i,
    output logic [csr_pkg::XLEN-1:0]       prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,

    // request to the lanes
    output logic [NUM_HARTS-1:0]           req_o,
    output csr_pkg::csr_op_e               op_o,
    output logic [csr_pkg::CSR_ADDR_W-1:0] addr_o,
    output logic [csr_pkg::XLEN-1:0]       operand_o,
    output logic [NUM_HARTS-1:0]           int_assert_o,

    // completion from the collector
    input  logic                           done_i,
    input  logic [csr_pkg::XLEN-1:0]       result_i,
    input  logic                           err_i
);
    import csr_pkg::*;

    // at least one select bit even for a single hart
    localparam int HART_SEL_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1;

    // decoded access
    logic                  wr_access;
    logic                  cmd_write;
    logic [CMD_HART_W-1:0] cmd_hart;
    logic                  hart_ok;
    logic                  cmd_accept;
    logic [HART_SEL_W-1:0] hart_sel;

    // host visible state
    logic [XLEN-1:0]       operand_q;
    logic [NUM_HARTS-1:0]  int_q;
    logic                  busy_q;
    logic [CMD_HART_W-1:0] hart_q;
    logic [CSR_ADDR_W-1:0] addr_q;
    csr_op_e               op_q;

    // apb access phase write
    assign wr_access = psel_i & penable_i & pwrite_i;
    assign cmd_write = wr_access & (paddr_i == REG_CMD);

    // hart field of the incoming command
    assign cmd_hart = pwdata_i[CMD_HART_LSB +: CMD_HART_W];
    assign hart_ok = int'(cmd_hart) < NUM_HARTS;
    assign hart_sel = cmd_hart[HART_SEL_W-1:0];

    // one command in flight at a time
    assign cmd_accept = cmd_write & ~busy_q & hart_ok;

    // zero wait states
    assign pready_o = 1'b1;
    // rejected command shows up in the same access cycle
    assign pslverr_o = cmd_write & (busy_q | ~hart_ok);

    // operand and interrupt registers
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            operand_q <= '0;
            int_q <= '0;
        end else if (wr_access) begin
            if (paddr_i == REG_OPERAND) begin
                operand_q <= pwdata_i;
            end
            if (paddr_i == REG_INT) begin
                int_q <= pwdata_i[NUM_HARTS-1:0];
            end
        end
    end

    // busy flag and request strobe
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            req_o <= '0;
        end else begin
            req_o <= '0;
            if (cmd_accept) begin
                busy_q <= 1'b1;
                req_o[hart_sel] <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // latched command fields, held for the lane
    always_ff @(posedge clk_i) begin
        if (cmd_accept) begin
            addr_q <= pwdata_i[CMD_ADDR_LSB +: CSR_ADDR_W];
            op_q <= csr_op_e'(pwdata_i[CMD_OP_LSB +: CSR_OP_W]);
            hart_q <= cmd_hart;
        end
    end

    assign op_o = op_q;
    assign addr_o = addr_q;
    assign operand_o = operand_q;
    assign int_assert_o = int_q;

    // read mux, unmapped offsets return zero
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            REG_OPERAND: prdata_o = operand_q;
            REG_CMD: begin
                // last accepted command
                prdata_o[CMD_ADDR_LSB +: CSR_ADDR_W] = addr_q;
                prdata_o[CMD_OP_LSB +: CSR_OP_W] = op_q;
                prdata_o[CMD_HART_LSB +: CMD_HART_W] = hart_q;
            end
            REG_INT: prdata_o[NUM_HARTS-1:0] = int_q;
            REG_STATUS: begin
                prdata_o[STATUS_BUSY_BIT] = busy_q;
                prdata_o[STATUS_ERR_BIT] = err_i;
            end
            REG_RESULT: prdata_o = result_i;
            default: prdata_o = '0;
        endcase
    end

endmodule

// ==== logic/csr_result_collect.sv ====
`timescale 1ns/10ps

module csr_result_collect #(
    parameter int NUM_HARTS = 4
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    // responses from all lanes
    input  logic [NUM_HARTS-1:0]                rsp_valid_i,
    input  logic [NUM_HARTS-1:0][csr_pkg::XLEN-1:0] rsp_data_i,
    input  logic [NUM_HARTS-1:0]                rsp_err_i,

    // completion to the frontend
    output logic                                done_o,
    output logic [csr_pkg::XLEN-1:0]            result_o,
    output logic                                err_o
);
    import csr_pkg::*;

    logic            any_valid;
    logic [XLEN-1:0] data_or;
    logic            err_or;

    // at most one lane answers per command
    assign any_valid = |rsp_valid_i;

    // merge the valid lane, idle lanes masked off
    always_comb begin
        data_or = '0;
        err_or = 1'b0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (rsp_valid_i[h]) begin
                data_or = data_or | rsp_data_i[h];
                err_or = err_or | rsp_err_i[h];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            done_o <= 1'b0;
            result_o <= '0;
            err_o <= 1'b0;
        end else begin
            // done lines up with the registered result
            done_o <= any_valid;
            if (any_valid) begin
                result_o <= data_or;
                err_o <= err_or;
            end
        end
    end

endmodule

// ==== logic/csr_cluster_top.sv ====
`timescale 1ns/10ps

module csr_cluster_top #(
    parameter int NUM_HARTS = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // apb slave
    input  logic [csr_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [csr_pkg::XLEN-1:0]       pwdata_i,
    output logic [csr_pkg::XLEN-1:0]       prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o
);
    import csr_pkg::*;

    // frontend to lanes
    logic [NUM_HARTS-1:0]            req;
    csr_op_e                         op;
    logic [CSR_ADDR_W-1:0]           addr;
    logic [XLEN-1:0]                 operand;
    logic [NUM_HARTS-1:0]            int_assert;

    // lanes to collector
    logic [NUM_HARTS-1:0]            rsp_valid;
    logic [NUM_HARTS-1:0][XLEN-1:0]  rsp_data;
    logic [NUM_HARTS-1:0]            rsp_err;

    // collector to frontend
    logic                            done;
    logic [XLEN-1:0]                 result;
    logic                            err;

    csr_apb_frontend #(
        .NUM_HARTS (NUM_HARTS)
    ) u_frontend (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .paddr_i      (paddr_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .req_o        (req),
        .op_o         (op),
        .addr_o       (addr),
        .operand_o    (operand),
        .int_assert_o (int_assert),
        .done_i       (done),
        .result_i     (result),
        .err_i        (err)
    );

    // one lane per hart, index becomes mhartid
    for (genvar h = 0; h < NUM_HARTS; h++) begin : g_lane
        csr_hart_lane #(
            .HART_ID (h)
        ) u_lane (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .req_i        (req[h]),
            .op_i         (op),
            .addr_i       (addr),
            .operand_i    (operand),
            .int_assert_i (int_assert[h]),
            .rsp_valid_o  (rsp_valid[h]),
            .rsp_data_o   (rsp_data[h]),
            .rsp_err_o    (rsp_err[h])
        );
    end

    csr_result_collect #(
        .NUM_HARTS (NUM_HARTS)
    ) u_collect (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rsp_valid_i (rsp_valid),
        .rsp_data_i  (rsp_data),
        .rsp_err_i   (rsp_err),
        .done_o      (done),
        .result_o    (result),
        .err_o       (err)
    );

endmodule

// ==== tb/csr_tb_tasks.svh ====
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

// model slot of a csr address
// -1 when no lane holds it
function automatic int csr_slot(input logic [CSR_ADDR_W-1:0] addr);
    case (addr)
        ADDR_MSTATUS: return 0;
        ADDR_MIE: return 1;
        ADDR_MTVEC: return 2;
        ADDR_MSCRATCH: return 3;
        ADDR_MEPC: return 4;
        ADDR_MCAUSE: return 5;
        ADDR_MHARTID: return SLOT_MHARTID;
        default: return -1;
    endcase
endfunction

// inverse of csr_slot
function automatic logic [CSR_ADDR_W-1:0] slot_addr(input int slot);
    case (slot)
        0: return ADDR_MSTATUS;
        1: return ADDR_MIE;
        2: return ADDR_MTVEC;
        3: return ADDR_MSCRATCH;
        4: return ADDR_MEPC;
        5: return ADDR_MCAUSE;
        default: return ADDR_MHARTID;
    endcase
endfunction

// cmd word with addr in [11:0], op in [13:12] and hart in [23:16]
function automatic logic [XLEN-1:0] cmd_word(input int hart, input logic [CSR_ADDR_W-1:0] addr,
                                             input csr_op_e op);
    logic [XLEN-1:0] w;
    w = '0;
    w[11:0] = addr;
    w[13:12] = op;
    w[23:16] = hart[7:0];
    return w;
endfunction

// all csrs clear and mhartid holds the hart index
task automatic model_reset();
    for (int h = 0; h < NUM_HARTS; h++) begin
        for (int s = 0; s < NUM_CSRS; s++) begin
            model_csr[h][s] = '0;
        end
        model_csr[h][SLOT_MHARTID] = XLEN'(h);
    end
    model_int = '0;
endtask

// expected response of one command
// the model is updated in place
task automatic model_csr_op(input int hart, input logic [CSR_ADDR_W-1:0] addr,
                            input csr_op_e op, input logic [XLEN-1:0] operand,
                            output logic [XLEN-1:0] exp_data, output logic exp_err);
    int              slot;
    logic [XLEN-1:0] old;
    slot = csr_slot(addr);
    exp_data = '0;
    // unknown address flags an error even while blocked
    exp_err = (slot < 0);
    if (slot >= 0 && !model_int[hart]) begin
        old = model_csr[hart][slot];
        exp_data = old;
        // mhartid never changes
        if (slot != SLOT_MHARTID) begin
            case (op)
                CSR_OP_RW: model_csr[hart][slot] = operand;
                CSR_OP_RS: model_csr[hart][slot] = old | operand;
                CSR_OP_RC: model_csr[hart][slot] = old & ~operand;
                default: ;
            endcase
        end
    end
endtask

task automatic check_value(input string what, input logic [XLEN-1:0] expected,
                           input logic [XLEN-1:0] actual);
    assert (actual === expected) else begin
        $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
                 cur_test, what, expected, actual);
        err_count++;
    end
endtask

task automatic begin_test(input string name);
    cur_test = name;
    test_errs_at_start = err_count;
    tests_run++;
endtask

task automatic end_test();
    if (err_count == test_errs_at_start) begin
        $display("[TEST] %s: pass", cur_test);
    end else begin
        tests_failed++;
        $display("[TEST] %s: fail, %0d errors", cur_test, err_count - test_errs_at_start);
    end
endtask

// setup then access phase
// entered and left on a falling edge
task automatic apb_transfer(input logic is_write, input logic [APB_ADDR_W-1:0] addr,
                            input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata,
                            output logic slverr);
    int waits;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = is_write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    // sample in the middle of the low phase
    #2;
    waits = 0;
    while (pready !== 1'b1 && waits < READY_LIMIT) begin
        @(negedge clk);
        #2;
        waits++;
    end
    assert (pready === 1'b1) else begin
        $display("%s: pready stayed low for %0d cycles at offset 0x%02h",
                 cur_test, waits, addr);
        err_count++;
    end
    rdata = prdata;
    slverr = pslverr;
    @(negedge clk);
    // bus idle unless the next transfer follows at once
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
endtask

task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [XLEN-1:0] data,
                         output logic slverr);
    logic [XLEN-1:0] unused_rdata;
    apb_transfer(1'b1, addr, data, unused_rdata, slverr);
endtask

task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [XLEN-1:0] data);
    logic slverr;
    apb_transfer(1'b0, addr, '0, data, slverr);
endtask

// poll status until busy drops
task automatic wait_idle(output logic [XLEN-1:0] status);
    int polls;
    polls = 0;
    apb_read(REG_STATUS, status);
    while (status[STATUS_BUSY_BIT] !== 1'b0 && polls < POLL_LIMIT) begin
        apb_read(REG_STATUS, status);
        polls++;
    end
    assert (status[STATUS_BUSY_BIT] === 1'b0) else begin
        $display("%s: busy did not clear after %0d status reads", cur_test, polls + 1);
        err_count++;
    end
endtask

// one full command with result and error bit checked against the model
task automatic run_csr(input int hart, input logic [CSR_ADDR_W-1:0] addr, input csr_op_e op,
                       input logic [XLEN-1:0] operand);
    logic [XLEN-1:0] exp_data;
    logic            exp_err;
    logic            slverr;
    logic [XLEN-1:0] status;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] readback;
    model_csr_op(hart, addr, op, operand, exp_data, exp_err);
    apb_write(REG_OPERAND, operand, slverr);
    apb_write(REG_CMD, cmd_word(hart, addr, op), slverr);
    check_value("cmd pslverr", '0, XLEN'(slverr));
    wait_idle(status);
    apb_read(REG_RESULT, result);
    check_value($sformatf("hart %0d csr 0x%03h result", hart, addr), exp_data, result);
    check_value($sformatf("hart %0d csr 0x%03h error bit", hart, addr),
                XLEN'(exp_err), XLEN'(status[STATUS_ERR_BIT]));
    // host registers keep what was written
    apb_read(REG_CMD, readback);
    check_value("cmd readback", cmd_word(hart, addr, op), readback);
    apb_read(REG_OPERAND, readback);
    check_value("operand readback", operand, readback);
endtask

// csrrs with zero operand reads without side effect
task automatic read_back(input int hart, input logic [CSR_ADDR_W-1:0] addr);
    run_csr(hart, addr, CSR_OP_RS, '0);
endtask

task automatic set_int(input logic [NUM_HARTS-1:0] mask);
    logic            slverr;
    logic [XLEN-1:0] readback;
    apb_write(REG_INT, XLEN'(mask), slverr);
    check_value("int pslverr", '0, XLEN'(slverr));
    apb_read(REG_INT, readback);
    check_value("int readback", XLEN'(mask), readback);
    model_int = mask;
endtask

task automatic test_reset_values();
    begin_test("reset_values");
    for (int h = 0; h < NUM_HARTS; h++) begin
        for (int s = 0; s < NUM_CSRS; s++) begin
            read_back(h, slot_addr(s));
        end
    end
    end_test();
endtask

task automatic test_rw_swap();
    begin_test("rw_swap");
    // second swap hands back the first operand
    for (int h = 0; h < NUM_HARTS; h++) begin
        run_csr(h, ADDR_MSCRATCH, CSR_OP_RW, $urandom());
        run_csr(h, ADDR_MSCRATCH, CSR_OP_RW, $urandom());
    end
    // each lane kept its own value
    for (int h = 0; h < NUM_HARTS; h++) begin
        read_back(h, ADDR_MSCRATCH);
    end
    end_test();
endtask

task automatic test_set_clear();
    begin_test("set_clear");
    for (int h = 0; h < NUM_HARTS; h++) begin
        run_csr(h, ADDR_MTVEC, CSR_OP_RW, $urandom());
        run_csr(h, ADDR_MTVEC, CSR_OP_RS, $urandom());
        read_back(h, ADDR_MTVEC);
        run_csr(h, ADDR_MTVEC, CSR_OP_RC, $urandom());
        read_back(h, ADDR_MTVEC);
    end
    run_csr(0, ADDR_MSTATUS, CSR_OP_RS, $urandom());
    run_csr(0, ADDR_MSTATUS, CSR_OP_RC, $urandom());
    read_back(0, ADDR_MSTATUS);
    end_test();
endtask

task automatic test_int_block();
    begin_test("int_block");
    run_csr(1, ADDR_MEPC, CSR_OP_RW, $urandom());
    run_csr(2, ADDR_MEPC, CSR_OP_RW, $urandom());
    // hart 1 blocked while hart 2 stays live
    set_int(4'b0010);
    run_csr(1, ADDR_MEPC, CSR_OP_RW, $urandom());
    run_csr(2, ADDR_MEPC, CSR_OP_RW, $urandom());
    set_int('0);
    // blocked write left mepc alone
    read_back(1, ADDR_MEPC);
    run_csr(1, ADDR_MEPC, CSR_OP_RW, $urandom());
    read_back(1, ADDR_MEPC);
    end_test();
endtask

task automatic test_bad_addr();
    logic            slverr;
    logic [XLEN-1:0] status;
    begin_test("bad_addr");
    run_csr(3, 12'h7C0, CSR_OP_RW, $urandom());
    // mhartid swap returns the id without error
    run_csr(2, ADDR_MHARTID, CSR_OP_RW, $urandom());
    read_back(2, ADDR_MHARTID);
    // hart index past the last lane is refused and starts nothing
    apb_write(REG_CMD, cmd_word(NUM_HARTS, ADDR_MSCRATCH, CSR_OP_RW), slverr);
    check_value("out of range hart pslverr", XLEN'(1), XLEN'(slverr));
    apb_read(REG_STATUS, status);
    check_value("out of range hart busy bit", '0, XLEN'(status[STATUS_BUSY_BIT]));
    end_test();
endtask

task automatic test_busy_reject();
    logic [XLEN-1:0] first_op;
    logic [XLEN-1:0] exp_data;
    logic            exp_err;
    logic            slverr;
    logic [XLEN-1:0] status;
    logic [XLEN-1:0] result;
    begin_test("busy_reject");
    first_op = $urandom();
    run_csr(0, ADDR_MCAUSE, CSR_OP_RW, $urandom());
    model_csr_op(0, ADDR_MCAUSE, CSR_OP_RW, first_op, exp_data, exp_err);
    apb_write(REG_OPERAND, first_op, slverr);
    apb_write(REG_CMD, cmd_word(0, ADDR_MCAUSE, CSR_OP_RW), slverr);
    check_value("first cmd pslverr", '0, XLEN'(slverr));
    // next transfer lands while busy
    apb_write(REG_CMD, cmd_word(3, ADDR_MCAUSE, CSR_OP_RW), slverr);
    check_value("second cmd pslverr", XLEN'(1), XLEN'(slverr));
    wait_idle(status);
    apb_read(REG_RESULT, result);
    check_value("first cmd result", exp_data, result);
    check_value("first cmd error bit", XLEN'(exp_err), XLEN'(status[STATUS_ERR_BIT]));
    read_back(0, ADDR_MCAUSE);
    // rejected command never reached hart 3
    read_back(3, ADDR_MCAUSE);
    end_test();
endtask

`endif

// ==== tb/tb_csr_cluster.sv ====
`timescale 1ns/10ps

module tb_csr_cluster;
    import csr_pkg::*;

    localparam int NUM_HARTS = 4;
    // model slots per hart, mhartid kept in the last one
    localparam int NUM_CSRS = 7;
    localparam int SLOT_MHARTID = 6;
    // cycles allowed for pready, status reads allowed for busy
    localparam int READY_LIMIT = 8;
    localparam int POLL_LIMIT = 16;

    // apb master side
    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [XLEN-1:0]       pwdata;
    logic [XLEN-1:0]       prdata;
    logic                  pready;
    logic                  pslverr;

    // reference state, one row per hart
    logic [XLEN-1:0]       model_csr [NUM_HARTS][NUM_CSRS];
    logic [NUM_HARTS-1:0]  model_int;

    // per test and overall counters
    string                 cur_test;
    int                    err_count = 0;
    int                    test_errs_at_start = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    // 8 ns period
    always #4 clk = ~clk;

    csr_cluster_top #(
        .NUM_HARTS (NUM_HARTS)
    ) UUT (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    `include "csr_tb_tasks.svh"

    initial begin
        void'($urandom(32'h5fd2));
        rst_n = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        model_reset();

        // sync reset held for 16 cycles, released on a falling edge
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        test_reset_values();
        test_rw_swap();
        test_set_clear();
        test_int_block();
        test_bad_addr();
        test_busy_reject();

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+tb
logic/csr_pkg.sv
logic/exu_csr_unit.sv
logic/csr_hart_lane.sv
logic/csr_apb_frontend.sv
logic/csr_result_collect.sv
logic/csr_cluster_top.sv
tb/tb_csr_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the CSR cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f sim.f --top-module tb_csr_cluster -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_csr_cluster" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi

exit 0
